//--- hdl/csr_defs.svh
// CSR unit widths and constants
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data width of every machine CSR on RV64
`define CSR_XLEN 64

// rename index width, the destination tag carries 5 more bits on top of it
`define CSR_RB 6

// misa reads as MXL=2 (64 bit) with only the I extension present
`define CSR_MISA_VALUE 64'h8000_0000_0000_0100

// machine information registers
// a zero vendor id means a non-commercial implementation
`define CSR_VENDOR_ID 64'h0

// architecture and implementation ids are not allocated yet
`define CSR_ARCH_ID 64'h0

`define CSR_IMP_ID 64'h0

// single hart core, so the hart id is always zero
`define CSR_HART_ID 64'h0

`endif

//--- hdl/csr_pkg.sv
// CSR architecture types
package csr_pkg;

	// field view of a CSR address as laid out by the privileged spec
	// access 2'b11 marks the read-only block of addresses
	typedef struct packed {
		logic [1:0] access;
		logic [1:0] priv;
		logic [7:0] index;
	} csr_addr_fields_t;

	// the same 12 bits are matched whole against the address map
	// and split into fields for the read-only check
	typedef union packed {
		logic [11:0]      raw;
		csr_addr_fields_t f;
	} csr_addr_u;

	// operation carried by the issue packet
	// none is a plain read with no update
	typedef enum logic [1:0] {
		csr_op_none  = 2'd0,
		csr_op_write = 2'd1,
		csr_op_set   = 2'd2,
		csr_op_clear = 2'd3
	} csr_op_e;

	// machine information registers, all read-only
	localparam logic [11:0] addr_mvendorid = 12'hF11;
	localparam logic [11:0] addr_marchid   = 12'hF12;
	localparam logic [11:0] addr_mimpid    = 12'hF13;
	localparam logic [11:0] addr_mhartid   = 12'hF14;

	// machine trap setup
	localparam logic [11:0] addr_mstatus   = 12'h300;
	localparam logic [11:0] addr_misa      = 12'h301;
	localparam logic [11:0] addr_mie       = 12'h304;
	localparam logic [11:0] addr_mtvec     = 12'h305;

	// machine trap handling
	localparam logic [11:0] addr_mepc      = 12'h341;
	localparam logic [11:0] addr_mcause    = 12'h342;
	localparam logic [11:0] addr_mtval     = 12'h343;
	localparam logic [11:0] addr_mip       = 12'h344;

endpackage

//--- hdl/exe_pkg.sv
// CSR pipeline packet types
`include "csr_defs.svh"

package exe_pkg;

	// issue packet from dispatch
	// valid is a one-cycle strobe, one packet may come every cycle
	typedef struct packed {
		logic                  valid;
		csr_pkg::csr_op_e      op;
		csr_pkg::csr_addr_u    addr;
		logic [`CSR_XLEN-1:0]  operand;
		logic [5+`CSR_RB-1:0]  rd;
	} csr_issue_t;

	// writeback packet to the rename and commit side
	// result holds the old CSR value, or zero on an illegal or suppressed read
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic [5+`CSR_RB-1:0]  rd;
		logic [`CSR_XLEN-1:0]  result;
	} csr_wb_t;

	// request from the exec stage to the register block
	// addr also selects the combinational read port
	typedef struct packed {
		csr_pkg::csr_addr_u    addr;
		logic                  wen;
		logic [`CSR_XLEN-1:0]  wdata;
	} csr_wr_t;

endpackage

//--- hdl/csr_regfile.sv
// Machine CSR register block
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  exe_pkg::csr_wr_t      wr,
	output logic [`CSR_XLEN-1:0]  rdata,
	output logic                  hit
);

	// writable machine trap setup registers
	logic [`CSR_XLEN-1:0] mstatus;
	logic [`CSR_XLEN-1:0] mie;
	logic [`CSR_XLEN-1:0] mtvec;

	// writable machine trap handling registers
	logic [`CSR_XLEN-1:0] mepc;
	logic [`CSR_XLEN-1:0] mcause;
	logic [`CSR_XLEN-1:0] mtval;
	logic [`CSR_XLEN-1:0] mip;

	// the whole register is replaced, no WARL field masking is done here
	// the exec stage has already merged set and clear into wdata
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mstatus <= '0;
			mie     <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
			mtval   <= '0;
			mip     <= '0;
		end else if (wr.wen) begin
			// only one register changes per cycle, picked by the raw address
			case (wr.addr.raw)
				csr_pkg::addr_mstatus: mstatus <= wr.wdata;
				csr_pkg::addr_mie:     mie     <= wr.wdata;
				csr_pkg::addr_mtvec:   mtvec   <= wr.wdata;
				csr_pkg::addr_mepc:    mepc    <= wr.wdata;
				csr_pkg::addr_mcause:  mcause  <= wr.wdata;
				csr_pkg::addr_mtval:   mtval   <= wr.wdata;
				csr_pkg::addr_mip:     mip     <= wr.wdata;
				// constants and unknown addresses never reach here with wen set
				default: ;
			endcase
		end
	end

	// read port depends on the address only
	// so there is no combinational path from wen back into the exec stage
	always_comb begin
		rdata = '0;
		hit   = 1'b1;
		case (wr.addr.raw)
			// machine information constants
			csr_pkg::addr_mvendorid: rdata = `CSR_VENDOR_ID;
			csr_pkg::addr_marchid:   rdata = `CSR_ARCH_ID;
			csr_pkg::addr_mimpid:    rdata = `CSR_IMP_ID;
			csr_pkg::addr_mhartid:   rdata = `CSR_HART_ID;
			// misa sits in the writable block but is held constant here
			csr_pkg::addr_misa:      rdata = `CSR_MISA_VALUE;
			// writable registers
			csr_pkg::addr_mstatus:   rdata = mstatus;
			csr_pkg::addr_mie:       rdata = mie;
			csr_pkg::addr_mtvec:     rdata = mtvec;
			csr_pkg::addr_mepc:      rdata = mepc;
			csr_pkg::addr_mcause:    rdata = mcause;
			csr_pkg::addr_mtval:     rdata = mtval;
			csr_pkg::addr_mip:       rdata = mip;
			// anything else is unimplemented and reads as zero
			default: begin
				rdata = '0;
				hit   = 1'b0;
			end
		endcase
	end

	// the exec stage must drop the write when the address is unimplemented
	a_no_write_on_miss: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.wen |-> hit
	) else $error("csr_regfile: write to unimplemented address %h", wr.addr.raw);

	// the exec stage must drop the write when the address is read-only
	a_no_write_read_only: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.wen |-> (wr.addr.f.access != 2'b11)
	) else $error("csr_regfile: write to read-only address %h", wr.addr.raw);

endmodule

//--- hdl/csr_exec.sv
// CSR execution stage
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_exec (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  flush,
	input  exe_pkg::csr_issue_t   issue,
	output exe_pkg::csr_wr_t      wr,
	input  logic [`CSR_XLEN-1:0]  rdata,
	input  logic                  hit,
	output exe_pkg::csr_wb_t      wb
);

	// issue that survives the flush in the same cycle
	logic issue_go;

	// suppression rules taken from the instruction encoding
	logic dont_read;
	logic dont_write;

	// a write to the register would happen if the access were legal
	logic wants_write;

	// access field of all ones is the read-only block
	logic read_only;
	logic illegal;

	// merged value for the register block
	logic [`CSR_XLEN-1:0] new_value;

	assign issue_go = issue.valid & ~flush;

	// csrrw with rd = x0 must not produce a read side effect
	assign dont_read = (issue.op == csr_pkg::csr_op_write) && (issue.rd == '0);

	// csrrs and csrrc with a zero source must not write
	assign dont_write = ((issue.op == csr_pkg::csr_op_set) ||
		(issue.op == csr_pkg::csr_op_clear)) && (issue.operand == '0);

	assign wants_write = (issue.op != csr_pkg::csr_op_none) && !dont_write;

	assign read_only = (issue.addr.f.access == 2'b11);

	// unknown addresses are illegal for any access
	// read-only addresses only when a write would really take place
	assign illegal = !hit || (read_only && wants_write);

	// new value from the old one and the operand
	always_comb begin
		case (issue.op)
			csr_pkg::csr_op_write: new_value = issue.operand;
			csr_pkg::csr_op_set:   new_value = rdata | issue.operand;
			csr_pkg::csr_op_clear: new_value = rdata & ~issue.operand;
			// a plain read leaves the register as it is
			default:               new_value = rdata;
		endcase
	end

	// the write goes out in the issue cycle and lands at the next edge
	// together with the writeback, so a back-to-back access sees it
	assign wr.addr  = issue.addr;
	assign wr.wen   = issue_go && wants_write && !illegal;
	assign wr.wdata = new_value;

	// the writeback register loads one cycle after the issue
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
		end else begin
			wb.valid   <= issue_go;
			// illegal is only meaningful together with valid
			wb.illegal <= issue_go && illegal;
			if (issue_go) begin
				wb.rd <= issue.rd;
				// old value, or zero when the read is suppressed or illegal
				if (illegal || dont_read) begin
					wb.result <= '0;
				end else begin
					wb.result <= rdata;
				end
			end
		end
	end

	// every unflushed issue gives a writeback on the next edge
	a_wb_follows_issue: assert property (
		@(posedge clk) disable iff (!arst_n)
		(issue.valid && !flush) |=> wb.valid
	) else $error("csr_exec: writeback missing after issue");

	// an illegal access must never leak CSR contents
	a_illegal_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		(wb.valid && wb.illegal) |-> (wb.result == '0)
	) else $error("csr_exec: illegal writeback with result %h", wb.result);

endmodule

//--- hdl/csr_unit.sv
// CSR execution unit top
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_unit (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 flush,
	input  exe_pkg::csr_issue_t  issue,
	output exe_pkg::csr_wb_t     wb
);

	// request from the exec stage, its address also drives the read port
	exe_pkg::csr_wr_t     wr;

	// combinational read result and address hit from the register block
	logic [`CSR_XLEN-1:0] rdata;
	logic                 hit;

	// decode, rules and the registered writeback
	csr_exec exec_i (
		.clk    (clk),
		.arst_n (arst_n),
		.flush  (flush),
		.issue  (issue),
		.wr     (wr),
		.rdata  (rdata),
		.hit    (hit),
		.wb     (wb)
	);

	// machine CSRs and constants
	csr_regfile regfile_i (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (wr),
		.rdata  (rdata),
		.hit    (hit)
	);

endmodule

//--- testbench/csr_unit_tb.sv
// CSR unit testbench
`timescale 1ns/10ps
`include "csr_defs.svh"

module csr_unit_tb;

	// 40 ns clock period with inputs changing 2 ns after each rising edge
	localparam int half_period  = 20;
	localparam int drive_delay  = 2;
	localparam int reset_cycles = 2;
	localparam int n_rand       = 30;

	// misa for RV64 is MXL=2 in the top two bits and I is extension letter 8
	localparam logic [`CSR_XLEN-1:0] misa_rv64i = (64'd2 << 62) | (64'd1 << 8);

	// short names keep the table rows readable
	localparam csr_pkg::csr_op_e op_rd  = csr_pkg::csr_op_none;
	localparam csr_pkg::csr_op_e op_wr  = csr_pkg::csr_op_write;
	localparam csr_pkg::csr_op_e op_set = csr_pkg::csr_op_set;
	localparam csr_pkg::csr_op_e op_clr = csr_pkg::csr_op_clear;

	// one row of stimulus together with the writeback it should produce
	typedef struct packed {
		csr_pkg::csr_op_e      op;
		logic [11:0]           addr;
		logic [`CSR_XLEN-1:0]  operand;
		logic [5+`CSR_RB-1:0]  rd;
		logic                  flush;
		logic                  exp_valid;
		logic                  exp_illegal;
		logic [`CSR_XLEN-1:0]  exp_result;
	} entry_t;

	logic                 clk;
	logic                 arst_n;
	logic                 flush;
	exe_pkg::csr_issue_t  issue;
	exe_pkg::csr_wb_t     wb;

	entry_t stim_q[$];

	int     n_tests;
	int     n_fail;
	int     cycles;
	int     cycle_limit;
	integer seed;

	csr_unit dut_i (
		.clk    (clk),
		.arst_n (arst_n),
		.flush  (flush),
		.issue  (issue),
		.wb     (wb)
	);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// the run is bounded by the number of issued packets plus some slack
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic string op_text(input csr_pkg::csr_op_e op);
		case (op)
			csr_pkg::csr_op_write: return "write";
			csr_pkg::csr_op_set:   return "set  ";
			csr_pkg::csr_op_clear: return "clear";
			default:               return "read ";
		endcase
	endfunction

	task automatic add_entry(
		input csr_pkg::csr_op_e     op,
		input logic [11:0]          addr,
		input logic [`CSR_XLEN-1:0] operand,
		input logic [5+`CSR_RB-1:0] rd,
		input logic                 fl,
		input logic                 exp_valid,
		input logic                 exp_illegal,
		input logic [`CSR_XLEN-1:0] exp_result
	);
		entry_t e;
		e.op          = op;
		e.addr        = addr;
		e.operand     = operand;
		e.rd          = rd;
		e.flush       = fl;
		e.exp_valid   = exp_valid;
		e.exp_illegal = exp_illegal;
		e.exp_result  = exp_result;
		stim_q.push_back(e);
	endtask

	// the task starts 2 ns after an edge and the packet is taken at the next edge
	// the writeback is looked at 1 ns after that edge once it has settled
	task automatic apply_entry(input entry_t e, input string section);
		bit ok;
		ok = 1'b1;
		issue.valid    = 1'b1;
		issue.op       = e.op;
		issue.addr.raw = e.addr;
		issue.operand  = e.operand;
		issue.rd       = e.rd;
		flush          = e.flush;
		@(posedge clk);
		#1;
		assert (wb.valid === e.exp_valid) else begin
			$display("** Error: wb.valid is %h, expected %h", wb.valid, e.exp_valid);
			ok = 1'b0;
		end
		// tag, flag and result only mean something on a strobe
		if (e.exp_valid) begin
			assert (wb.illegal === e.exp_illegal) else begin
				$display("** Error: wb.illegal is %h, expected %h", wb.illegal, e.exp_illegal);
				ok = 1'b0;
			end
			assert (wb.rd === e.rd) else begin
				$display("** Error: wb.rd is %h, expected %h", wb.rd, e.rd);
				ok = 1'b0;
			end
			assert (wb.result === e.exp_result) else begin
				$display("** Error: wb.result is %h, expected %h", wb.result, e.exp_result);
				ok = 1'b0;
			end
		end
		n_tests = n_tests + 1;
		if (!ok)
			n_fail = n_fail + 1;
		$display("test %0d %s %s addr %h flush %0d: %s", n_tests, section, op_text(e.op),
			e.addr, e.flush, ok ? "ok" : "FAILED");
		#(drive_delay - 1);
	endtask

	initial begin : main
		entry_t                e;
		logic [`CSR_XLEN-1:0]  shadow_mtvec;
		logic [`CSR_XLEN-1:0]  expect_result;
		logic [31:0]           r_hi;
		logic [31:0]           r_lo;
		logic [31:0]           r_rd;

		arst_n  = 1'b0;
		flush   = 1'b0;
		issue   = '0;
		n_tests = 0;
		n_fail  = 0;
		cycles  = 0;
		seed    = 32'hdf22;

		// every writable CSR is zero after reset and the constants read as defined
		add_entry(op_rd, csr_pkg::addr_mstatus, 64'h0, 11'd1, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mie, 64'h0, 11'd2, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mtvec, 64'h0, 11'd3, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mepc, 64'h0, 11'd4, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mcause, 64'h0, 11'd5, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mtval, 64'h0, 11'd6, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mip, 64'h0, 11'd7, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_misa, 64'h0, 11'd8, 0, 1, 0, misa_rv64i);
		add_entry(op_rd, csr_pkg::addr_mhartid, 64'h0, 11'd9, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mvendorid, 64'h0, 11'd10, 0, 1, 0, 64'h0);

		// write, set, clear and read back with each returning the value before it
		add_entry(op_wr, csr_pkg::addr_mstatus, 64'h1888, 11'h21, 0, 1, 0, 64'h0);
		add_entry(op_set, csr_pkg::addr_mstatus, 64'hA000_0000_0000_0001, 11'h22, 0, 1, 0,
			64'h1888);
		add_entry(op_clr, csr_pkg::addr_mstatus, 64'h0808, 11'h23, 0, 1, 0,
			64'hA000_0000_0000_1889);
		add_entry(op_rd, csr_pkg::addr_mstatus, 64'h0, 11'h24, 0, 1, 0, 64'hA000_0000_0000_1081);
		add_entry(op_wr, csr_pkg::addr_mie, 64'hAAA, 11'h25, 0, 1, 0, 64'h0);
		add_entry(op_set, csr_pkg::addr_mie, 64'h555, 11'h26, 0, 1, 0, 64'hAAA);
		add_entry(op_clr, csr_pkg::addr_mie, 64'h0F0, 11'h27, 0, 1, 0, 64'hFFF);
		add_entry(op_rd, csr_pkg::addr_mie, 64'h0, 11'h28, 0, 1, 0, 64'hF0F);
		add_entry(op_wr, csr_pkg::addr_mepc, 64'h8000_0000_1234_5678, 11'h29, 0, 1, 0, 64'h0);
		add_entry(op_set, csr_pkg::addr_mepc, 64'h1, 11'h2A, 0, 1, 0, 64'h8000_0000_1234_5678);
		add_entry(op_clr, csr_pkg::addr_mepc, 64'h8000_0000_0000_0000, 11'h2B, 0, 1, 0,
			64'h8000_0000_1234_5679);
		add_entry(op_rd, csr_pkg::addr_mepc, 64'h0, 11'h2C, 0, 1, 0, 64'h1234_5679);
		add_entry(op_wr, csr_pkg::addr_mcause, 64'h8000_0000_0000_000B, 11'h2D, 0, 1, 0, 64'h0);
		add_entry(op_set, csr_pkg::addr_mcause, 64'h4, 11'h2E, 0, 1, 0, 64'h8000_0000_0000_000B);
		add_entry(op_clr, csr_pkg::addr_mcause, 64'h8000_0000_0000_0000, 11'h2F, 0, 1, 0,
			64'h8000_0000_0000_000F);
		add_entry(op_rd, csr_pkg::addr_mcause, 64'h0, 11'h30, 0, 1, 0, 64'hF);

		// write to tag zero hides the old value but still lands
		add_entry(op_wr, csr_pkg::addr_mtval, 64'hDEAD_BEEF, 11'h0, 0, 1, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mtval, 64'h0, 11'h31, 0, 1, 0, 64'hDEAD_BEEF);
		// zero operand on set or clear is a pure read
		add_entry(op_set, csr_pkg::addr_mtval, 64'h0, 11'h32, 0, 1, 0, 64'hDEAD_BEEF);
		add_entry(op_clr, csr_pkg::addr_mtval, 64'h0, 11'h33, 0, 1, 0, 64'hDEAD_BEEF);
		add_entry(op_rd, csr_pkg::addr_mtval, 64'h0, 11'h34, 0, 1, 0, 64'hDEAD_BEEF);
		// no write happens, so a read-only CSR is a legal target here
		add_entry(op_set, csr_pkg::addr_mhartid, 64'h0, 11'h35, 0, 1, 0, 64'h0);

		// illegal accesses return zero with the flag up and change nothing
		add_entry(op_wr, csr_pkg::addr_mhartid, 64'h5, 11'h40, 0, 1, 1, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mhartid, 64'h0, 11'h41, 0, 1, 0, 64'h0);
		add_entry(op_wr, csr_pkg::addr_mvendorid, 64'h1234, 11'h42, 0, 1, 1, 64'h0);
		add_entry(op_set, csr_pkg::addr_marchid, 64'h1, 11'h43, 0, 1, 1, 64'h0);
		add_entry(op_rd, 12'h7C0, 64'h0, 11'h44, 0, 1, 1, 64'h0);
		add_entry(op_wr, 12'h345, 64'hFFFF, 11'h45, 0, 1, 1, 64'h0);
		add_entry(op_clr, 12'h306, 64'hFF, 11'h46, 0, 1, 1, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mstatus, 64'h0, 11'h47, 0, 1, 0, 64'hA000_0000_0000_1081);

		// a flushed issue gives neither a write nor a strobe
		add_entry(op_wr, csr_pkg::addr_mip, 64'h888, 11'h50, 1, 0, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mip, 64'h0, 11'h51, 0, 1, 0, 64'h0);
		add_entry(op_wr, csr_pkg::addr_mip, 64'h80, 11'h52, 0, 1, 0, 64'h0);
		add_entry(op_set, csr_pkg::addr_mip, 64'h8, 11'h53, 1, 0, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mip, 64'h0, 11'h54, 0, 1, 0, 64'h80);
		add_entry(op_wr, csr_pkg::addr_mhartid, 64'h7, 11'h55, 1, 0, 0, 64'h0);
		add_entry(op_rd, 12'h7C0, 64'h0, 11'h56, 1, 0, 0, 64'h0);
		add_entry(op_rd, csr_pkg::addr_mip, 64'h0, 11'h57, 0, 1, 0, 64'h80);

		cycle_limit = stim_q.size() + n_rand + reset_cycles + 20;

		repeat (reset_cycles) @(posedge clk);
		#(drive_delay);
		arst_n = 1'b1;

		foreach (stim_q[i])
			apply_entry(stim_q[i], "table ");

		// mtvec was only read so far, so the shadow copy starts at zero
		shadow_mtvec = '0;
		for (int i = 0; i < n_rand; i++) begin
			r_hi = $random(seed);
			r_lo = $random(seed);
			r_rd = $random(seed);
			e.addr    = csr_pkg::addr_mtvec;
			e.operand = {r_hi, r_lo};
			e.rd      = r_rd[5+`CSR_RB-1:0];
			// a nonzero tag keeps the old value visible on every write
			e.rd[0]   = 1'b1;
			e.flush   = 1'b0;
			case (i % 3)
				0:       e.op = op_wr;
				1:       e.op = op_set;
				default: e.op = op_clr;
			endcase
			expect_result = shadow_mtvec;
			if (e.op == op_wr)
				shadow_mtvec = e.operand;
			else if (e.op == op_set && e.operand != '0)
				shadow_mtvec = shadow_mtvec | e.operand;
			else if (e.op == op_clr && e.operand != '0)
				shadow_mtvec = shadow_mtvec & ~e.operand;
			e.exp_valid   = 1'b1;
			e.exp_illegal = 1'b0;
			e.exp_result  = expect_result;
			apply_entry(e, "random");
		end

		issue = '0;
		flush = 1'b0;

		$display("tests run %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
		if (n_fail == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/exe_pkg.sv
hdl/csr_regfile.sv
hdl/csr_exec.sv
hdl/csr_unit.sv
testbench/csr_unit_tb.sv
